// File: logic/eth_rx_macros.svh
`ifndef ETH_RX_MACROS_SVH
`define ETH_RX_MACROS_SVH

// Word-address width of the receive buffer
// 9 bits give 512 words of 32 bits, 2048 bytes in all
`define ETH_RX_BUFFER_W 9

// Preamble nibble, repeated until the delimiter
`define ETH_RX_PRE_NIBBLE 4'h5

// Second nibble of the delimiter byte D5
`define ETH_RX_SFD_NIBBLE 4'hD

// Left in the CRC register after a good frame with its FCS
`define ETH_RX_CRC_RESIDUE 32'hC704DD7B

`endif

// File: logic/eth_mii_pkg.sv
`include "eth_rx_macros.svh"

package eth_mii_pkg;

   // One nibble on MRxD
   typedef logic [3:0] mii_nibble_t;

   typedef logic [7:0] eth_byte_t;  // Assembled receive byte

   // Byte address or byte count within one frame
   // Bits [1:0] pick the lane in a buffer word, the rest the word
   typedef logic [`ETH_RX_BUFFER_W+1:0] frame_len_t;

   typedef logic [31:0] crc_t;  // CRC-32 register value

endpackage

// File: logic/eth_buf_pkg.sv
`include "eth_rx_macros.svh"

package eth_buf_pkg;

   // One buffer word, byte 0 in bits [7:0]
   typedef logic [31:0] buf_word_t;

   typedef logic [3:0] buf_strobe_t;  // One write enable per lane

   // Word address into the receive buffer
   typedef logic [`ETH_RX_BUFFER_W-1:0] buf_addr_t;

endpackage

// File: logic/eth_crc32.sv
`include "eth_rx_macros.svh"

module eth_crc32 (
   input  logic                   MRxClk,
   input  logic                   ETH_PHY_RESETN,
   input  logic                   clear_i,
   input  logic                   en_i,
   input  eth_mii_pkg::eth_byte_t byte_i,
   output eth_mii_pkg::crc_t      crc_o,
   output logic                   crc_ok_o
);

   import eth_mii_pkg::*;

   localparam crc_t CRC_POLY = 32'h04C11DB7;

   crc_t crc_q;
   crc_t crc_nxt;

   // Eight serial steps per byte
   // Bit 0 goes first, the order the bits leave the wire
   always_comb begin
      crc_nxt = crc_q;
      for (int i = 0; i < 8; i++) begin
         if (crc_nxt[31] ^ byte_i[i]) begin
            crc_nxt = {crc_nxt[30:0], 1'b0} ^ CRC_POLY;
         end else begin
            crc_nxt = {crc_nxt[30:0], 1'b0};
         end
      end
   end

   always_ff @(posedge MRxClk, negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) crc_q <= '1;
      else if (clear_i) crc_q <= '1;  // Preset on each delimiter
      else if (en_i) crc_q <= crc_nxt;
   end

   // FCS bytes run through the register too
   // A clean frame then leaves the fixed residue
   assign crc_o    = crc_q;
   assign crc_ok_o = (crc_q == `ETH_RX_CRC_RESIDUE);

   // Delimiter and data bytes never share a cycle
   a_clear_en: assert property (@(posedge MRxClk) disable iff (!ETH_PHY_RESETN)
      !(clear_i && en_i));

endmodule

// File: logic/eth_rx_mii.sv
`include "eth_rx_macros.svh"

module eth_rx_mii (
   input  logic                     MRxClk,
   input  logic                     ETH_PHY_RESETN,
   input  eth_mii_pkg::mii_nibble_t mrxd_i,
   input  logic                     mrxdv_i,
   input  logic                     rcv_ack_i,
   input  logic                     crc_ok_i,
   output logic                     crc_clear_o,
   output logic                     crc_en_o,
   output eth_mii_pkg::eth_byte_t   crc_byte_o,
   output logic                     wr_o,
   output eth_mii_pkg::frame_len_t  wr_addr_o,
   output eth_mii_pkg::eth_byte_t   wr_byte_o,
   output logic                     data_rcvd_o,
   output logic                     crc_err_o,
   output eth_mii_pkg::frame_len_t  nbytes_o,
   output logic                     phy_dv_detected_o
);

   import eth_mii_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PREAMBLE,
      ST_DATA,
      ST_END,
      ST_HELD
   } rx_state_t;

   rx_state_t   state;
   logic        half;       // Low nibble already taken, high one next
   logic        byte_vld;   // One cycle per completed byte
   mii_nibble_t lo_nibble;
   eth_byte_t   rx_byte;
   frame_len_t  byte_cnt;   // Address of the next byte to store

   // Frame FSM
   always_ff @(posedge MRxClk, negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state       <= ST_IDLE;
         half        <= 1'b0;
         byte_vld    <= 1'b0;
         crc_clear_o <= 1'b0;
         byte_cnt    <= '0;
         data_rcvd_o <= 1'b0;
         crc_err_o   <= 1'b0;
         nbytes_o    <= '0;
      end else begin
         crc_clear_o <= 1'b0;
         byte_vld    <= 1'b0;

         // Count moves on once the byte has been written
         if (byte_vld) byte_cnt <= byte_cnt + 1'b1;

         case (state)
            ST_IDLE: begin
               if (mrxdv_i && mrxd_i == `ETH_RX_PRE_NIBBLE) state <= ST_PREAMBLE;
            end

            ST_PREAMBLE: begin
               if (!mrxdv_i) begin
                  state <= ST_IDLE;  // No delimiter, frame dropped
               end else if (mrxd_i == `ETH_RX_SFD_NIBBLE) begin
                  state       <= ST_DATA;
                  half        <= 1'b0;
                  crc_clear_o <= 1'b1;
                  byte_cnt    <= '0;
               end
            end

            ST_DATA: begin
               if (!mrxdv_i) begin
                  state <= ST_END;  // Odd trailing nibble is simply dropped
               end else begin
                  half     <= ~half;
                  byte_vld <= half;
               end
            end

            // Last CRC update has landed by now
            ST_END: begin
               state       <= ST_HELD;
               data_rcvd_o <= 1'b1;
               crc_err_o   <= ~crc_ok_i;
               nbytes_o    <= byte_cnt;
            end

            ST_HELD: begin
               if (rcv_ack_i) data_rcvd_o <= 1'b0;
               // Wait for the line to go quiet before the next preamble
               if ((rcv_ack_i || !data_rcvd_o) && !mrxdv_i) state <= ST_IDLE;
            end

            default: state <= ST_IDLE;
         endcase
      end
   end

   // Nibble pairing, low nibble first on the wire
   always_ff @(posedge MRxClk) begin
      if (state == ST_DATA && mrxdv_i) begin
         if (!half) lo_nibble <= mrxd_i;
         else rx_byte <= {mrxd_i, lo_nibble};
      end
   end

   // Sticky until reset
   always_ff @(posedge MRxClk, negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) phy_dv_detected_o <= 1'b0;
      else if (mrxdv_i) phy_dv_detected_o <= 1'b1;
   end

   // Buffer and CRC see the same byte in the same cycle
   assign wr_o       = byte_vld;
   assign crc_en_o   = byte_vld;
   assign wr_byte_o  = rx_byte;
   assign crc_byte_o = rx_byte;
   assign wr_addr_o  = byte_cnt;

   // Held status blocks the buffer
   a_no_wr_held: assert property (@(posedge MRxClk) disable iff (!ETH_PHY_RESETN)
      !(wr_o && data_rcvd_o));

   // Frame may not run past the last byte of the buffer
   a_no_wrap: assert property (@(posedge MRxClk) disable iff (!ETH_PHY_RESETN)
      (wr_o && (&wr_addr_o)) |=> (!wr_o until crc_clear_o));

endmodule

// File: logic/eth_rx_buffer.sv
`include "eth_rx_macros.svh"

module eth_rx_buffer (
   input  logic                    MRxClk,
   input  logic                    wr_i,
   input  eth_mii_pkg::frame_len_t wr_addr_i,
   input  eth_mii_pkg::eth_byte_t  wr_byte_i,
   input  logic                    rd_en_i,
   input  eth_buf_pkg::buf_addr_t  rd_addr_i,
   output eth_buf_pkg::buf_word_t  rd_data_o
);

   import eth_buf_pkg::*;

   localparam int DEPTH = 1 << `ETH_RX_BUFFER_W;
   localparam int LANES = $bits(buf_strobe_t);

   buf_word_t   mem [DEPTH];
   buf_word_t   wr_word;   // Byte moved into its lane
   buf_strobe_t wr_strb;
   buf_addr_t   wr_waddr;

   assign wr_waddr = wr_addr_i[`ETH_RX_BUFFER_W+1:2];
   assign wr_word  = buf_word_t'(wr_byte_i) << {wr_addr_i[1:0], 3'b000};

   // One lane per byte in little-endian order
   always_comb begin
      wr_strb = '0;
      if (wr_i) wr_strb[wr_addr_i[1:0]] = 1'b1;
   end

   always_ff @(posedge MRxClk) begin
      for (int b = 0; b < LANES; b++) begin
         if (wr_strb[b]) mem[wr_waddr][8*b +: 8] <= wr_word[8*b +: 8];
      end
      if (rd_en_i) rd_data_o <= mem[rd_addr_i];  // Holds between reads
   end

   // A write lands a known byte at a known address on one lane
   a_strb_onehot: assert property (@(posedge MRxClk)
      wr_i |-> $onehot(wr_strb) && !$isunknown({wr_addr_i, wr_byte_i}));

endmodule

// File: logic/eth_rx_core.sv
module eth_rx_core (
   input  logic                     MRxClk,
   input  logic                     ETH_PHY_RESETN,
   input  eth_mii_pkg::mii_nibble_t mrxd_i,
   input  logic                     mrxdv_i,
   input  logic                     rcv_ack_i,
   input  logic                     rd_en_i,
   input  eth_buf_pkg::buf_addr_t   rd_addr_i,
   output logic                     data_rcvd_o,
   output logic                     crc_err_o,
   output eth_mii_pkg::frame_len_t  nbytes_o,
   output logic                     phy_dv_detected_o,
   output eth_buf_pkg::buf_word_t   rd_data_o
);

   import eth_mii_pkg::*;

   // Receiver to CRC checker
   logic       crc_clear;
   logic       crc_en;
   eth_byte_t  crc_byte;
   logic       crc_ok;

   // Receiver to buffer
   logic       wr;
   frame_len_t wr_addr;
   eth_byte_t  wr_byte;

   eth_rx_mii rx (
      .MRxClk           (MRxClk),
      .ETH_PHY_RESETN   (ETH_PHY_RESETN),
      .mrxd_i           (mrxd_i),
      .mrxdv_i          (mrxdv_i),
      .rcv_ack_i        (rcv_ack_i),
      .crc_ok_i         (crc_ok),
      .crc_clear_o      (crc_clear),
      .crc_en_o         (crc_en),
      .crc_byte_o       (crc_byte),
      .wr_o             (wr),
      .wr_addr_o        (wr_addr),
      .wr_byte_o        (wr_byte),
      .data_rcvd_o      (data_rcvd_o),
      .crc_err_o        (crc_err_o),
      .nbytes_o         (nbytes_o),
      .phy_dv_detected_o(phy_dv_detected_o)
   );

   // Only the residue verdict is needed here
   eth_crc32 crc (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .clear_i       (crc_clear),
      .en_i          (crc_en),
      .byte_i        (crc_byte),
      .crc_o         (),
      .crc_ok_o      (crc_ok)
   );

   eth_rx_buffer rx_buffer (
      .MRxClk   (MRxClk),
      .wr_i     (wr),
      .wr_addr_i(wr_addr),
      .wr_byte_i(wr_byte),
      .rd_en_i  (rd_en_i),    // Host side
      .rd_addr_i(rd_addr_i),
      .rd_data_o(rd_data_o)
   );

endmodule

// File: test/eth_rx_model.svh
`ifndef ETH_RX_MODEL_SVH
`define ETH_RX_MODEL_SVH

localparam int BUF_BYTES = 4 << `ETH_RX_BUFFER_W;

eth_byte_t   tx_bytes[$];     // Payload then FCS, as sent on the wire
mii_nibble_t tx_nibbles[$];   // Whole nibble stream of one frame
eth_byte_t   exp_mem [BUF_BYTES];  // Unwritten bytes stay X like the RAM
frame_len_t  exp_len;
logic        exp_err;

// Reflected Ethernet CRC-32, final value complemented
function automatic crc_t ref_crc32(input eth_byte_t data[$]);
   crc_t c;
   c = 32'hFFFF_FFFF;
   foreach (data[i]) begin
      c = c ^ crc_t'(data[i]);
      for (int k = 0; k < 8; k++) begin
         c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
   end
   return ~c;
endfunction

// Random payload, FCS low byte first, optional bit flip and stray nibble
task automatic build_frame(input int len, input bit corrupt, input bit half);
   crc_t fcs;
   int   pre_len;
   int   bit_pos;
   tx_bytes.delete();
   tx_nibbles.delete();
   for (int i = 0; i < len; i++) begin
      tx_bytes.push_back(eth_byte_t'($urandom));
   end
   fcs = ref_crc32(tx_bytes);
   for (int i = 0; i < 4; i++) begin
      tx_bytes.push_back(fcs[8*i +: 8]);
   end
   if (corrupt) begin
      bit_pos = $urandom_range(8 * tx_bytes.size() - 1);
      tx_bytes[bit_pos / 8][bit_pos % 8] = ~tx_bytes[bit_pos / 8][bit_pos % 8];
   end
   pre_len = $urandom_range(15, 1);
   repeat (pre_len) tx_nibbles.push_back(`ETH_RX_PRE_NIBBLE);
   tx_nibbles.push_back(`ETH_RX_SFD_NIBBLE);
   foreach (tx_bytes[i]) begin
      tx_nibbles.push_back(tx_bytes[i][3:0]);  // Low nibble goes first
      tx_nibbles.push_back(tx_bytes[i][7:4]);
   end
   if (half) tx_nibbles.push_back(mii_nibble_t'($urandom));
endtask

// Preamble that never reaches a delimiter
task automatic build_preamble_only(input int count);
   tx_bytes.delete();
   tx_nibbles.delete();
   repeat (count) tx_nibbles.push_back(`ETH_RX_PRE_NIBBLE);
endtask

// Frame bytes land from byte address zero
task automatic store_expected();
   foreach (tx_bytes[i]) exp_mem[i] = tx_bytes[i];
   exp_len = frame_len_t'(tx_bytes.size());
endtask

// Byte 0 of a word sits in the low lane
function automatic buf_word_t expected_word(input int addr);
   return {exp_mem[4*addr+3], exp_mem[4*addr+2], exp_mem[4*addr+1], exp_mem[4*addr]};
endfunction

`endif

// File: test/eth_rx_core_tb.sv
`include "eth_rx_macros.svh"

module eth_rx_core_tb;

   import eth_mii_pkg::*;
   import eth_buf_pkg::*;

   localparam int unsigned SEED = 32'he46809f1;
   localparam int RESET_CYCLES   = 8;
   localparam int RCV_TIMEOUT    = 20;   // Cycles from MRxDv low to the status
   localparam int QUIET_CYCLES   = 30;
   localparam int IFG_CYCLES     = 4;
   localparam int GOOD_FRAMES    = 10;
   localparam int CORRUPT_FRAMES = 6;
   localparam int HALF_FRAMES    = 4;

   logic        MRxClk = 1'b0;
   logic        ETH_PHY_RESETN;
   mii_nibble_t mrxd_i;
   logic        mrxdv_i;
   logic        rcv_ack_i;
   logic        rd_en_i;
   buf_addr_t   rd_addr_i;
   logic        data_rcvd_o;
   logic        crc_err_o;
   frame_len_t  nbytes_o;
   logic        phy_dv_detected_o;
   buf_word_t   rd_data_o;

   `include "eth_rx_model.svh"

   eth_rx_core dut (
      .MRxClk           (MRxClk),
      .ETH_PHY_RESETN   (ETH_PHY_RESETN),
      .mrxd_i           (mrxd_i),
      .mrxdv_i          (mrxdv_i),
      .rcv_ack_i        (rcv_ack_i),
      .rd_en_i          (rd_en_i),
      .rd_addr_i        (rd_addr_i),
      .data_rcvd_o      (data_rcvd_o),
      .crc_err_o        (crc_err_o),
      .nbytes_o         (nbytes_o),
      .phy_dv_detected_o(phy_dv_detected_o),
      .rd_data_o        (rd_data_o)
   );

   always #5 MRxClk = ~MRxClk;

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Error %s: expected %b, actual %b", name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "Status bit mismatch");
      end
   endtask

   task automatic check_len(input string name, input frame_len_t exp, input frame_len_t act);
      if (act !== exp) begin
         $display("Error %s: expected %0d, actual %0d", name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "Byte count mismatch");
      end
   endtask

   task automatic check_word(input string name, input buf_word_t exp, input buf_word_t act);
      if (act !== exp) begin
         $display("Error %s: expected %h, actual %h", name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "Buffer word mismatch");
      end
   endtask

   // One nibble per edge, then MRxDv low
   task automatic send_nibbles();
      foreach (tx_nibbles[i]) begin
         @(posedge MRxClk);
         mrxdv_i <= 1'b1;
         mrxd_i  <= tx_nibbles[i];
      end
      @(posedge MRxClk);
      mrxdv_i <= 1'b0;
      mrxd_i  <= '0;
   endtask

   task automatic wait_rcvd(input string name);
      int cycles;
      cycles = 0;
      @(negedge MRxClk);
      while (data_rcvd_o !== 1'b1) begin
         if (cycles == RCV_TIMEOUT) begin
            $display("Timeout in %s: the frame received flag never rose", name);
            $display("Simulation FAILED");
            $fatal(1, "Receive timeout");
         end
         cycles++;
         @(negedge MRxClk);
      end
   endtask

   // Flag must keep one value for a while
   task automatic observe_rcvd(input string name, input logic exp, input int cycles);
      repeat (cycles) begin
         @(negedge MRxClk);
         check_bit(name, exp, data_rcvd_o);
      end
   endtask

   task automatic read_word(input buf_addr_t addr, output buf_word_t data);
      @(posedge MRxClk);
      rd_en_i   <= 1'b1;
      rd_addr_i <= addr;
      @(posedge MRxClk);
      rd_en_i <= 1'b0;
      @(negedge MRxClk);
      data = rd_data_o;
   endtask

   task automatic verify_status(input string name);
      @(negedge MRxClk);
      check_bit({name, " data_rcvd"}, 1'b1, data_rcvd_o);
      check_bit({name, " crc_err"}, exp_err, crc_err_o);
      check_len({name, " nbytes"}, exp_len, nbytes_o);
   endtask

   task automatic verify_buffer(input string name);
      buf_word_t act;
      int        words;
      words = (int'(exp_len) + 3) / 4;
      for (int a = 0; a < words; a++) begin
         read_word(buf_addr_t'(a), act);
         check_word($sformatf("%s word %0d", name, a), expected_word(a), act);
      end
   endtask

   task automatic ack_frame(input string name);
      @(posedge MRxClk);
      rcv_ack_i <= 1'b1;
      @(posedge MRxClk);
      rcv_ack_i <= 1'b0;
      @(negedge MRxClk);
      check_bit({name, " after ack"}, 1'b0, data_rcvd_o);
      repeat (IFG_CYCLES) @(posedge MRxClk);
   endtask

   task automatic receive_frame(input string name, input int len, input bit corrupt,
                                input bit half);
      build_frame(len, corrupt, half);
      send_nibbles();
      wait_rcvd(name);
      store_expected();
      exp_err = corrupt;
      verify_status(name);
      verify_buffer(name);
   endtask

   initial begin
      void'($urandom(SEED));
      ETH_PHY_RESETN <= 1'b0;
      mrxd_i         <= '0;
      mrxdv_i        <= 1'b0;
      rcv_ack_i      <= 1'b0;
      rd_en_i        <= 1'b0;
      rd_addr_i      <= '0;
      repeat (RESET_CYCLES) @(posedge MRxClk);
      ETH_PHY_RESETN <= 1'b1;

      // Reset state, line still idle
      repeat (3) @(negedge MRxClk);
      check_bit("reset data_rcvd", 1'b0, data_rcvd_o);
      check_bit("reset crc_err", 1'b0, crc_err_o);
      check_bit("reset phy_dv", 1'b0, phy_dv_detected_o);
      check_len("reset nbytes", '0, nbytes_o);

      for (int f = 0; f < GOOD_FRAMES; f++) begin
         receive_frame($sformatf("good %0d", f), $urandom_range(200, 1), 1'b0, 1'b0);
         check_bit("phy_dv after frame", 1'b1, phy_dv_detected_o);
         ack_frame($sformatf("good %0d", f));
      end

      for (int f = 0; f < CORRUPT_FRAMES; f++) begin
         receive_frame($sformatf("corrupt %0d", f), $urandom_range(200, 1), 1'b1, 1'b0);
         ack_frame($sformatf("corrupt %0d", f));
      end

      for (int f = 0; f < HALF_FRAMES; f++) begin
         receive_frame($sformatf("half %0d", f), $urandom_range(200, 1), 1'b0, 1'b1);
         ack_frame($sformatf("half %0d", f));
      end

      // No delimiter, nothing may be reported
      build_preamble_only($urandom_range(24, 4));
      send_nibbles();
      observe_rcvd("no delimiter", 1'b0, QUIET_CYCLES);
      receive_frame("after no delimiter", $urandom_range(200, 1), 1'b0, 1'b0);

      // Second frame arrives while the first is still held
      build_frame($urandom_range(200, 1), 1'b0, 1'b0);
      send_nibbles();
      observe_rcvd("held", 1'b1, QUIET_CYCLES);
      verify_status("held");
      verify_buffer("held");
      ack_frame("held");
      receive_frame("after held", $urandom_range(200, 1), 1'b0, 1'b0);
      ack_frame("after held");

      check_bit("phy_dv at end", 1'b1, phy_dv_detected_o);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: eth_rx_core.f
+incdir+logic
+incdir+test
logic/eth_mii_pkg.sv
logic/eth_buf_pkg.sv
logic/eth_crc32.sv
logic/eth_rx_mii.sv
logic/eth_rx_buffer.sv
logic/eth_rx_core.sv
test/eth_rx_core_tb.sv
